// ==== list.f ====
+incdir+verilog
verilog/fm_pkg.sv
verilog/fm_host_axil.sv
verilog/fm_timer_a.sv
verilog/fm_reg_file.sv
verilog/fm_reg_top.sv
verification/fm_reg_assertions.sv
verification/fm_reg_tb.sv

// ==== verification/fm_reg_assertions.sv ====
// Bus and key-on rules of the FM register block
// Bound to the host and to the register file, absent ports tied inactive
`default_nettype none

module fm_reg_assertions (
	input wire clk,
	input wire rst,
	input wire busy,
	input wire bvalid,
	input wire bready,
	input wire kon_out,
	input wire koff_out
);

	int fail_count = 0;

	bvalid_hold: assert property (@(posedge clk) disable iff (rst)
		bvalid && !bready |=> bvalid)
		else begin
			fail_count++;
			$error("bvalid dropped before bready");
		end

	key_exclusive: assert property (@(posedge clk) disable iff (rst)
		!(kon_out && koff_out))
		else begin
			fail_count++;
			$error("kon_out and koff_out high together");
		end

	busy_after_reset: assert property (@(posedge clk) rst |=> !busy)
		else begin
			fail_count++;
			$error("busy high after reset");
		end

endmodule

bind fm_host_axil fm_reg_assertions bus_chk_i (
	.clk(clk), .rst(rst), .busy(busy), .bvalid(bvalid), .bready(bready),
	.kon_out(1'b0), .koff_out(1'b0)
);

bind fm_reg_file fm_reg_assertions key_chk_i (
	.clk(clk), .rst(rst), .busy(busy), .bvalid(1'b0), .bready(1'b1),
	.kon_out(kon_out), .koff_out(koff_out)
);

`default_nettype wire

// ==== verification/fm_reg_tb.sv ====
// Directed testbench of the FM register block
// Expected fields follow the OPM register bit layout
// Parameter values and targets come from $random with seed 22
// Outputs are sampled on the falling edge
`default_nettype none
`include "fm_macros.svh"

module fm_reg_tb;

	localparam int TIMEOUT_CYCLES = 4000; // Tests need about 1600 cycles

	logic clk, rst;
	logic [11:0] awaddr, araddr;
	logic awvalid, wvalid, bready, arvalid, rready;
	logic [31:0] wdata;
	logic [3:0] wstrb;
	wire awready, wready, bvalid, arready, rvalid;
	wire [1:0] bresp, rresp;
	wire [31:0] rdata;
	wire fm_pkg::slot_t slot;
	wire [1:0] rl, ams, ks, dt2;
	wire [2:0] fb, con, pms, dt1;
	wire [6:0] kc, tl;
	wire [5:0] kf;
	wire [3:0] mul, d1l, rr;
	wire [4:0] ar, d1r, d2r;
	wire amsen, kon_out, koff_out;

	integer seed = 22;
	int cycles = 0;
	int checks = 0;
	int errors = 0;
	int tests = 0;
	int test_errors;
	logic [7:0] exp_byte [6][`FM_SLOTS]; // Groups tl, dt1, d1l, ks, amsen, dt2
	logic exp_valid [6][`FM_SLOTS];

	fm_reg_top dut_i (.*);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	always @(posedge clk) begin
		cycles = cycles + 1;
		if (cycles >= TIMEOUT_CYCLES) begin
			$display("Timeout after %0d cycles, a DUT handshake never completed", cycles);
			$display("SIMULATION FAILED");
			$finish;
		end
	end

	task automatic check_slot(input string name, input fm_pkg::slot_t got,
		input fm_pkg::slot_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("ERROR t=%0t %s got %0d expected %0d", $time, name, got, exp);
		end
	endtask

	task automatic check_byte(input string name, input logic [7:0] got, input logic [7:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("ERROR t=%0t %s got %0h expected %0h", $time, name, got, exp);
		end
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("ERROR t=%0t %s got %b expected %b", $time, name, got, exp);
		end
	endtask

	task automatic end_test(input string name);
		tests++;
		$display("Test %s done with %0d errors", name, errors - test_errors);
		test_errors = errors;
	endtask

	task automatic axi_write(input logic [7:0] num, input logic [7:0] data);
		@(posedge clk);
		#1;
		awaddr = {2'b00, num, 2'b00};
		wdata = {24'd0, data};
		wstrb = 4'h1;
		awvalid = 1'b1;
		wvalid = 1'b1;
		bready = 1'b1;
		do
			@(negedge clk);
		while (!(awready && wready));
		@(posedge clk);
		#1;
		awvalid = 1'b0;
		wvalid = 1'b0;
		do
			@(negedge clk);
		while (!bvalid);
		check_byte("bresp", bresp, 8'h00);
		@(posedge clk);
		#1;
		bready = 1'b0;
	endtask

	task automatic axi_read(output logic [7:0] status);
		@(posedge clk);
		#1;
		araddr = 12'h000;
		arvalid = 1'b1;
		rready = 1'b1;
		do
			@(negedge clk);
		while (!arready);
		@(posedge clk);
		#1;
		arvalid = 1'b0;
		do
			@(negedge clk);
		while (!rvalid);
		status = rdata[7:0];
		check_byte("rresp", rresp, 8'h00);
		@(posedge clk);
		#1;
		rready = 1'b0;
	endtask

	task automatic wait_slot(input fm_pkg::slot_t target);
		do
			@(negedge clk);
		while (slot != target);
	endtask

	task automatic check_op_fields(input fm_pkg::slot_t s);
		if (exp_valid[0][s])
			check_byte("tl", tl, {1'b0, exp_byte[0][s][6:0]});
		if (exp_valid[1][s]) begin
			check_byte("dt1", dt1, exp_byte[1][s][6:4]);
			check_byte("mul", mul, exp_byte[1][s][3:0]);
		end
		if (exp_valid[2][s]) begin
			check_byte("d1l", d1l, exp_byte[2][s][7:4]);
			check_byte("rr", rr, exp_byte[2][s][3:0]);
		end
		if (exp_valid[3][s]) begin
			check_byte("ks", ks, exp_byte[3][s][7:6]);
			check_byte("ar", ar, exp_byte[3][s][4:0]);
		end
		if (exp_valid[4][s]) begin
			check_bit("amsen", amsen, exp_byte[4][s][7]);
			check_byte("d1r", d1r, exp_byte[4][s][4:0]);
		end
		if (exp_valid[5][s]) begin
			check_byte("dt2", dt2, exp_byte[5][s][7:6]);
			check_byte("d2r", d2r, exp_byte[5][s][4:0]);
		end
	endtask

	task automatic test_reset();
		logic [7:0] status;
		fm_pkg::slot_t exp_slot;
		check_bit("kon_out", kon_out, 1'b0);
		check_bit("koff_out", koff_out, 1'b0);
		check_bit("bvalid", bvalid, 1'b0);
		check_bit("rvalid", rvalid, 1'b0);
		exp_slot = '0; // Counter starts at 0 after reset
		repeat (4) begin
			@(negedge clk);
			check_slot("slot", slot, exp_slot);
			exp_slot = exp_slot + 1'b1;
		end
		axi_read(status);
		check_byte("status", status, 8'h00);
	endtask

	task automatic test_op_params();
		logic [7:0] bases [6];
		fm_pkg::slot_t target;
		logic [7:0] data;
		int g;
		bases = '{`FM_BASE_TL, `FM_BASE_DT1, `FM_BASE_D1L, `FM_BASE_KS, `FM_BASE_AMSEN,
			`FM_BASE_DT2};
		for (int j = 0; j < 6; j++) begin
			for (int s = 0; s < `FM_SLOTS; s++)
				exp_valid[j][s] = 1'b0;
		end
		for (int i = 0; i < 12; i++) begin
			g = i % 6;
			target = $random(seed);
			data = $random(seed);
			axi_write(bases[g] | target, data);
			exp_byte[g][target] = data;
			exp_valid[g][target] = 1'b1;
			wait_slot(target);
			check_op_fields(target);
		end
		for (int s = 0; s < `FM_SLOTS; s++) begin // One round over every slot
			wait_slot(s);
			check_op_fields(s);
		end
	endtask

	task automatic test_ch_params();
		fm_pkg::ch_t c;
		logic [7:0] d_rl, d_kc, d_kf, d_pms;
		c = $random(seed);
		d_rl = $random(seed);
		d_kc = $random(seed);
		d_kf = $random(seed);
		d_pms = $random(seed);
		axi_write(`FM_BASE_RL | c, d_rl);
		axi_write(`FM_BASE_KC | c, d_kc);
		axi_write(`FM_BASE_KF | c, d_kf);
		axi_write(`FM_BASE_PMS | c, d_pms);
		for (int o = 0; o < 4; o++) begin
			wait_slot({o[1:0], c});
			check_byte("rl", rl, d_rl[7:6]);
			check_byte("fb", fb, d_rl[5:3]);
			check_byte("con", con, d_rl[2:0]);
			check_byte("kc", kc, d_kc[6:0]);
			check_byte("kf", kf, d_kf[7:2]);
			check_byte("pms", pms, d_pms[6:4]);
			check_byte("ams", ams, d_pms[1:0]);
		end
	endtask

	task automatic test_keyon();
		fm_pkg::ch_t c;
		fm_pkg::slot_t sv;
		int kon_seen [`FM_SLOTS];
		int koff_seen [`FM_SLOTS];
		bit done;
		int span;
		c = $random(seed);
		done = 1'b0;
		span = 0;
		for (int s = 0; s < `FM_SLOTS; s++) begin
			kon_seen[s] = 0;
			koff_seen[s] = 0;
		end
		fork
			begin
				axi_write(`FM_BASE_KEYON, 8'h50 | c); // C1 and C2 on
				done = 1'b1;
			end
			while (!done) begin
				@(negedge clk);
				span++;
				if (kon_out)
					kon_seen[slot]++;
				if (koff_out)
					koff_seen[slot]++;
			end
		join
		if (span > 72) begin
			errors++;
			$display("Key-on write took %0d cycles, more than 72", span);
		end
		for (int s = 0; s < `FM_SLOTS; s++) begin
			sv = s;
			check_byte($sformatf("kon_out count slot %0d", s), kon_seen[s],
				sv[2:0] == c && sv[4:3] >= 2'd2);
			check_byte($sformatf("koff_out count slot %0d", s), koff_seen[s],
				sv[2:0] == c && sv[4:3] < 2'd2);
		end
	endtask

	task automatic test_timer();
		logic [7:0] status;
		axi_write(`FM_BASE_TA_HI, 8'hFF); // 1020 split as FF and 0
		axi_write(`FM_BASE_TA_LO, 8'h00);
		axi_write(`FM_BASE_CTRL, 8'h01);
		repeat (80) @(posedge clk);
		axi_read(status);
		check_bit("ta_flag before 4 rounds", status[0], 1'b0);
		repeat (80) @(posedge clk);
		axi_read(status);
		check_bit("ta_flag by 5 rounds", status[0], 1'b1);
		axi_write(`FM_BASE_CTRL, 8'h10);
		axi_read(status);
		check_bit("ta_flag after clear", status[0], 1'b0);
	endtask

	task automatic test_csm();
		int n_kon;
		int n_koff;
		n_kon = 0;
		n_koff = 0;
		axi_write(`FM_BASE_TA_HI, 8'hFF);
		axi_write(`FM_BASE_TA_LO, 8'h02); // 1022, overflow every 2 rounds
		axi_write(`FM_BASE_CTRL, 8'h01);
		axi_write(`FM_BASE_CTRL, 8'h80);
		do
			@(negedge clk);
		while (!kon_out);
		while (kon_out) begin
			n_kon++;
			@(negedge clk);
		end
		while (koff_out) begin
			n_koff++;
			@(negedge clk);
		end
		check_byte("CSM kon_out cycles", n_kon, 8'd32);
		check_byte("CSM koff_out cycles", n_koff, 8'd32);
		axi_write(`FM_BASE_CTRL, 8'h00);
	endtask

	initial begin
		int assert_fails;
		rst = 1'b1;
		awaddr = '0;
		awvalid = 1'b0;
		wdata = '0;
		wstrb = '0;
		wvalid = 1'b0;
		bready = 1'b0;
		araddr = '0;
		arvalid = 1'b0;
		rready = 1'b0;
		repeat (4) @(posedge clk);
		#1;
		rst = 1'b0;
		test_errors = 0;
		test_reset();
		end_test("reset state");
		test_op_params();
		end_test("operator parameters");
		test_ch_params();
		end_test("channel parameters");
		test_keyon();
		end_test("key-on");
		test_timer();
		end_test("timer A");
		test_csm();
		end_test("CSM");
		assert_fails = dut_i.host_i.bus_chk_i.fail_count + dut_i.regs_i.key_chk_i.fail_count;
		if (assert_fails != 0)
			$display("Bound assertions failed %0d times", assert_fails);
		errors += assert_fails;
		$display("Tests %0d, checks %0d, errors %0d", tests, checks, errors);
		if (errors == 0)
			$display("SIMULATION PASSED");
		else
			$display("SIMULATION FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// ==== verilog/fm_host_axil.sv ====
// AXI4-Lite front end of the FM register block
// One write or read at a time, no outstanding transactions
// Parameter and key-on writes answer only after the register file goes idle
// Every read returns status: busy in bit 7, timer A flag in bit 0
// Writes with wstrb[0] low are acknowledged and ignored
`default_nettype none
`include "fm_macros.svh"

module fm_host_axil (
	input wire clk,
	input wire rst,
	input wire [11:0] awaddr,
	input wire awvalid,
	output logic awready,
	input wire [31:0] wdata,
	input wire [3:0] wstrb,
	input wire wvalid,
	output logic wready,
	output logic [1:0] bresp,
	output logic bvalid,
	input wire bready,
	input wire [11:0] araddr,
	input wire arvalid,
	output logic arready,
	output logic [31:0] rdata,
	output logic [1:0] rresp,
	output logic rvalid,
	input wire rready,
	input wire busy,
	input wire ta_flag,
	output logic [7:0] d_in,
	output fm_pkg::op_t op,
	output fm_pkg::ch_t ch,
	output logic up_rl, up_kc, up_kf, up_pms,
	output logic up_dt1, up_tl, up_ks, up_amsen, up_dt2, up_d1l,
	output logic up_kon,
	output logic [`FM_TA_BITS-1:0] ta_value,
	output logic ta_load,
	output logic ta_clear_flag,
	output logic csm_en
);

	function automatic fm_pkg::reg_group_e decode_group(input logic [7:0] num);
		fm_pkg::reg_group_e g;
		g = fm_pkg::GRP_NONE;
		if (num == `FM_BASE_KEYON) g = fm_pkg::GRP_KEYON;
		else if (num == `FM_BASE_TA_HI) g = fm_pkg::GRP_TA_HI;
		else if (num == `FM_BASE_TA_LO) g = fm_pkg::GRP_TA_LO;
		else if (num == `FM_BASE_CTRL) g = fm_pkg::GRP_CTRL;
		else if ((num & 8'hF8) == `FM_BASE_RL) g = fm_pkg::GRP_RL;
		else if ((num & 8'hF8) == `FM_BASE_KC) g = fm_pkg::GRP_KC;
		else if ((num & 8'hF8) == `FM_BASE_KF) g = fm_pkg::GRP_KF;
		else if ((num & 8'hF8) == `FM_BASE_PMS) g = fm_pkg::GRP_PMS;
		else if ((num & 8'hE0) == `FM_BASE_DT1) g = fm_pkg::GRP_DT1;
		else if ((num & 8'hE0) == `FM_BASE_TL) g = fm_pkg::GRP_TL;
		else if ((num & 8'hE0) == `FM_BASE_KS) g = fm_pkg::GRP_KS;
		else if ((num & 8'hE0) == `FM_BASE_AMSEN) g = fm_pkg::GRP_AMSEN;
		else if ((num & 8'hE0) == `FM_BASE_DT2) g = fm_pkg::GRP_DT2;
		else if ((num & 8'hE0) == `FM_BASE_D1L) g = fm_pkg::GRP_D1L;
		return g;
	endfunction

	fm_pkg::host_state_e state;
	fm_pkg::reg_group_e grp;
	fm_pkg::reg_group_e wr_grp;
	logic accept_w, accept_r, slow_wr, strobe_on;

	assign wr_grp = wstrb[0] ? decode_group(awaddr[9:2]) : fm_pkg::GRP_NONE;
	assign slow_wr = !(wr_grp inside {fm_pkg::GRP_NONE, fm_pkg::GRP_TA_HI,
		fm_pkg::GRP_TA_LO, fm_pkg::GRP_CTRL}); // Needs a register file round

	assign accept_w = state == fm_pkg::HOST_IDLE && awvalid && wvalid && !rvalid;
	assign accept_r = state == fm_pkg::HOST_IDLE && arvalid && !rvalid && !(awvalid && wvalid);
	assign awready = accept_w;
	assign wready = accept_w;
	assign arready = accept_r; // Status is the only word, araddr is not decoded
	assign bvalid = state == fm_pkg::HOST_RESP;
	assign bresp = 2'b00;
	assign rresp = 2'b00;

	// Parameter strobes span the whole wait for the register file
	assign strobe_on = state == fm_pkg::HOST_STROBE || state == fm_pkg::HOST_WAIT_BUSY;
	assign up_rl = strobe_on && grp == fm_pkg::GRP_RL;
	assign up_kc = strobe_on && grp == fm_pkg::GRP_KC;
	assign up_kf = strobe_on && grp == fm_pkg::GRP_KF;
	assign up_pms = strobe_on && grp == fm_pkg::GRP_PMS;
	assign up_dt1 = strobe_on && grp == fm_pkg::GRP_DT1;
	assign up_tl = strobe_on && grp == fm_pkg::GRP_TL;
	assign up_ks = strobe_on && grp == fm_pkg::GRP_KS;
	assign up_amsen = strobe_on && grp == fm_pkg::GRP_AMSEN;
	assign up_dt2 = strobe_on && grp == fm_pkg::GRP_DT2;
	assign up_d1l = strobe_on && grp == fm_pkg::GRP_D1L;
	assign up_kon = state == fm_pkg::HOST_STROBE && grp == fm_pkg::GRP_KEYON; // Single cycle

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= fm_pkg::HOST_IDLE;
			grp <= fm_pkg::GRP_NONE;
			ta_load <= 1'b0;
			ta_clear_flag <= 1'b0;
			csm_en <= 1'b0;
			rvalid <= 1'b0;
		end else begin
			ta_load <= 1'b0;
			ta_clear_flag <= 1'b0;
			case (state)
				fm_pkg::HOST_IDLE: begin
					if (accept_w) begin
						grp <= wr_grp;
						state <= slow_wr ? fm_pkg::HOST_STROBE : fm_pkg::HOST_RESP;
						if (wr_grp == fm_pkg::GRP_CTRL) begin
							ta_load <= wdata[0];
							ta_clear_flag <= wdata[4];
							csm_en <= wdata[7];
						end
					end
				end
				fm_pkg::HOST_STROBE: begin
					// Key-on raises busy on its own next cycle
					if (grp == fm_pkg::GRP_KEYON || busy)
						state <= fm_pkg::HOST_WAIT_BUSY;
				end
				fm_pkg::HOST_WAIT_BUSY: begin
					if (!busy)
						state <= fm_pkg::HOST_RESP;
				end
				fm_pkg::HOST_RESP: begin
					if (bready)
						state <= fm_pkg::HOST_IDLE;
				end
			endcase
			if (accept_r)
				rvalid <= 1'b1;
			else if (rready)
				rvalid <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (accept_w) begin
			d_in <= wdata[7:0];
			op <= awaddr[6:5]; // Register number bits 4:3
			ch <= awaddr[4:2];
			if (wr_grp == fm_pkg::GRP_TA_HI)
				ta_value[9:2] <= wdata[7:0];
			if (wr_grp == fm_pkg::GRP_TA_LO)
				ta_value[1:0] <= wdata[1:0];
		end
		if (accept_r)
			rdata <= {24'd0, busy, 6'd0, ta_flag};
	end

endmodule

`default_nettype wire

// ==== verilog/fm_macros.svh ====
// Sizing and register map of the FM register block
// Register numbers are AXI address bits 9:2, data is the low byte
// The design only works with 32 slots and 8 channels
`ifndef FM_MACROS_SVH
`define FM_MACROS_SVH

`define FM_SLOTS    32
`define FM_CHANNELS 8
`define FM_TA_BITS  10

`define FM_BASE_KEYON 8'h08
`define FM_BASE_TA_HI 8'h10 // Timer A bits 9:2
`define FM_BASE_TA_LO 8'h11 // Timer A bits 1:0
`define FM_BASE_CTRL  8'h14
`define FM_BASE_RL    8'h20 // Channel groups, 8 registers each
`define FM_BASE_KC    8'h28
`define FM_BASE_KF    8'h30
`define FM_BASE_PMS   8'h38
`define FM_BASE_DT1   8'h40 // Operator groups, 32 registers each
`define FM_BASE_TL    8'h60
`define FM_BASE_KS    8'h80
`define FM_BASE_AMSEN 8'hA0
`define FM_BASE_DT2   8'hC0
`define FM_BASE_D1L   8'hE0

`endif

// ==== verilog/fm_pkg.sv ====
// Shared types of the FM register block
// A slot number holds the operator in bits 4:3 and the channel in bits 2:0
`default_nettype none

package fm_pkg;

	typedef logic [4:0] slot_t;
	typedef logic [1:0] op_t;
	typedef logic [2:0] ch_t;

	// Register group of a write, acts as the host opcode
	typedef enum logic [3:0] {
		GRP_NONE,
		GRP_KEYON,
		GRP_TA_HI,
		GRP_TA_LO,
		GRP_CTRL,
		GRP_RL,
		GRP_KC,
		GRP_KF,
		GRP_PMS,
		GRP_DT1,
		GRP_TL,
		GRP_KS,
		GRP_AMSEN,
		GRP_DT2,
		GRP_D1L
	} reg_group_e;

	typedef enum logic [1:0] {
		HOST_IDLE,
		HOST_STROBE,
		HOST_WAIT_BUSY,
		HOST_RESP
	} host_state_e;

endpackage

`default_nettype wire

// ==== verilog/fm_reg_file.sv ====
// Operator and channel parameter store of the FM engine
// The slot counter never stops, parameters of slot cur are valid in that cycle
// Memories have no reset, unwritten slots read undefined
// A parameter strobe must stay high for one full round of 32 slots
`default_nettype none
`include "fm_macros.svh"

module fm_reg_file (
	input wire clk,
	input wire rst,
	input wire [7:0] d_in,
	input wire up_rl, up_kc, up_kf, up_pms,
	input wire up_dt1, up_tl, up_ks, up_amsen, up_dt2, up_d1l,
	input wire up_kon,
	input wire fm_pkg::op_t op,
	input wire fm_pkg::ch_t ch,
	input wire csm_en,
	input wire csm_trig,
	output logic busy,
	output fm_pkg::slot_t cur_slot,
	output logic zero,
	output logic [1:0] rl_out,
	output logic [2:0] fb_out,
	output logic [2:0] con_out,
	output logic [6:0] kc_out,
	output logic [5:0] kf_out,
	output logic [2:0] pms_out,
	output logic [1:0] ams_out,
	output logic [2:0] dt1_out,
	output logic [3:0] mul_out,
	output logic [6:0] tl_out,
	output logic [1:0] ks_out,
	output logic [4:0] ar_out,
	output logic amsen_out,
	output logic [4:0] d1r_out,
	output logic [1:0] dt2_out,
	output logic [4:0] d2r_out,
	output logic [3:0] d1l_out,
	output logic [3:0] rr_out,
	output logic kon_out,
	output logic koff_out
);

	fm_pkg::slot_t cur, next, busy_start;
	logic up_any, up_last, busy_op, busy_kon;
	logic kon, koff, csm_kon, csm_koff;
	logic [4:0] csm_cnt;
	fm_pkg::op_t kon_step;
	fm_pkg::ch_t kon_ch;
	logic [3:0] kon_mask; // Indexed by operator field
	logic [41:0] op_mem [`FM_SLOTS];
	logic [25:0] ch_mem [`FM_CHANNELS];
	logic [41:0] op_word, op_merge;
	logic [25:0] ch_word, ch_merge;
	logic op_wr, ch_wr;

	assign next = cur + 1'b1;
	assign cur_slot = cur;
	assign busy = busy_op | busy_kon;
	assign up_any = |{up_rl, up_kc, up_kf, up_pms, up_dt1, up_tl, up_ks, up_amsen,
		up_dt2, up_d1l};

	// CSM phases override the key-on sequencer
	assign kon_out = csm_kon | (kon & !csm_koff);
	assign koff_out = csm_koff | (koff & !csm_kon);

	always_ff @(posedge clk) begin
		if (rst) begin
			cur <= '0;
			zero <= 1'b0;
			up_last <= 1'b0;
			busy_op <= 1'b0;
		end else begin
			cur <= next;
			zero <= cur == 5'd0;
			up_last <= up_any;
			if (up_any && !up_last) begin
				busy_op <= 1'b1;
				busy_start <= cur; // Busy for one round from here
			end else if (busy_op && busy_start == cur) begin
				busy_op <= 1'b0;
			end
		end
	end

	// Key-on visits M2, C1, C2, M1 at operator fields 1, 2, 3, 0
	always_ff @(posedge clk) begin
		if (rst) begin
			busy_kon <= 1'b0;
			kon_step <= '0;
			kon <= 1'b0;
			koff <= 1'b0;
		end else begin
			kon <= 1'b0;
			koff <= 1'b0;
			if (up_kon) begin
				busy_kon <= 1'b1;
				kon_step <= 2'd1;
			end else if (busy_kon && next == {kon_step, kon_ch}) begin
				kon <= kon_mask[kon_step];
				koff <= !kon_mask[kon_step];
				kon_step <= kon_step + 1'b1;
				if (kon_step == 2'd0)
					busy_kon <= 1'b0; // M1 is the last one
			end
		end
	end

	always_ff @(posedge clk) begin
		if (up_kon) begin
			kon_ch <= d_in[2:0];
			kon_mask <= {d_in[6], d_in[4], d_in[5], d_in[3]}; // C2 C1 M2 M1
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			csm_kon <= 1'b0;
			csm_koff <= 1'b0;
			csm_cnt <= '0;
		end else if (csm_en && csm_trig) begin
			csm_kon <= 1'b1;
			csm_koff <= 1'b0;
			csm_cnt <= '0;
		end else if (csm_kon || csm_koff) begin
			csm_cnt <= csm_cnt + 1'b1;
			if (&csm_cnt) begin
				csm_koff <= csm_kon; // Key-off phase follows key-on
				csm_kon <= 1'b0;
			end
		end
	end

	assign {dt1_out, mul_out, tl_out, ks_out, ar_out, amsen_out, d1r_out,
		dt2_out, d2r_out, d1l_out, rr_out} = op_word;
	assign {rl_out, fb_out, con_out, kc_out, kf_out, pms_out, ams_out} = ch_word;

	always_comb begin
		op_merge = op_word;
		if (up_dt1)
			op_merge[41:35] = d_in[6:0];
		if (up_tl)
			op_merge[34:28] = d_in[6:0];
		if (up_ks)
			op_merge[27:21] = {d_in[7:6], d_in[4:0]};
		if (up_amsen)
			op_merge[20:15] = {d_in[7], d_in[4:0]};
		if (up_dt2)
			op_merge[14:8] = {d_in[7:6], d_in[4:0]};
		if (up_d1l)
			op_merge[7:0] = d_in;
		ch_merge = ch_word;
		if (up_rl)
			ch_merge[25:18] = d_in;
		if (up_kc)
			ch_merge[17:11] = d_in[6:0];
		if (up_kf)
			ch_merge[10:5] = d_in[7:2];
		if (up_pms)
			ch_merge[4:0] = {d_in[6:4], d_in[1:0]};
	end

	assign op_wr = {op, ch} == cur && |{up_dt1, up_tl, up_ks, up_amsen, up_dt2, up_d1l};
	assign ch_wr = ch == cur[2:0] && |{up_rl, up_kc, up_kf, up_pms};

	// Read one slot ahead, write back the current slot
	always_ff @(posedge clk) begin
		op_word <= op_mem[next];
		ch_word <= ch_mem[next[2:0]];
		if (op_wr)
			op_mem[cur] <= op_merge;
		if (ch_wr)
			ch_mem[cur[2:0]] <= ch_merge;
	end

endmodule

`default_nettype wire

// ==== verilog/fm_reg_top.sv ====
// FM register block: AXI4-Lite host, timer A and parameter store
// Parameters of slot number slot are presented in the same cycle
`default_nettype none
`include "fm_macros.svh"

module fm_reg_top (
	input wire clk,
	input wire rst,
	input wire [11:0] awaddr,
	input wire awvalid,
	output wire awready,
	input wire [31:0] wdata,
	input wire [3:0] wstrb,
	input wire wvalid,
	output wire wready,
	output wire [1:0] bresp,
	output wire bvalid,
	input wire bready,
	input wire [11:0] araddr,
	input wire arvalid,
	output wire arready,
	output wire [31:0] rdata,
	output wire [1:0] rresp,
	output wire rvalid,
	input wire rready,
	output fm_pkg::slot_t slot,
	output wire [1:0] rl,
	output wire [2:0] fb, con,
	output wire [6:0] kc,
	output wire [5:0] kf,
	output wire [2:0] pms,
	output wire [1:0] ams,
	output wire [2:0] dt1,
	output wire [3:0] mul,
	output wire [6:0] tl,
	output wire [1:0] ks,
	output wire [4:0] ar,
	output wire amsen,
	output wire [4:0] d1r,
	output wire [1:0] dt2,
	output wire [4:0] d2r,
	output wire [3:0] d1l, rr,
	output wire kon_out,
	output wire koff_out
);

	wire [7:0] d_in;
	wire fm_pkg::op_t op;
	wire fm_pkg::ch_t ch;
	wire up_rl, up_kc, up_kf, up_pms, up_kon;
	wire up_dt1, up_tl, up_ks, up_amsen, up_dt2, up_d1l;
	wire busy, csm_en, round_tick;
	wire [`FM_TA_BITS-1:0] ta_value;
	wire ta_load, ta_clear_flag, ta_ovf, ta_flag;

	fm_host_axil host_i (.*);

	fm_timer_a timer_i (.*); // Ticks once per slot round

	fm_reg_file regs_i (
		.*,
		.csm_trig(ta_ovf),
		.cur_slot(slot),
		.zero(round_tick),
		.rl_out(rl), .fb_out(fb), .con_out(con),
		.kc_out(kc), .kf_out(kf), .pms_out(pms), .ams_out(ams),
		.dt1_out(dt1), .mul_out(mul), .tl_out(tl),
		.ks_out(ks), .ar_out(ar), .amsen_out(amsen), .d1r_out(d1r),
		.dt2_out(dt2), .d2r_out(d2r), .d1l_out(d1l), .rr_out(rr)
	);

endmodule

`default_nettype wire

// ==== verilog/fm_timer_a.sv ====
// Timer A, counts full slot rounds
// Stopped after reset until the first load
// Overflow reloads the counter, so the period is 1024 minus the value rounds
`default_nettype none
`include "fm_macros.svh"

module fm_timer_a (
	input wire clk,
	input wire rst,
	input wire round_tick,
	input wire [`FM_TA_BITS-1:0] ta_value,
	input wire ta_load,
	input wire ta_clear_flag,
	output logic ta_ovf,
	output logic ta_flag
);

	logic [`FM_TA_BITS-1:0] cnt;
	logic running;
	logic wrap;

	assign wrap = running && round_tick && (&cnt); // Tick that passes the top

	always_ff @(posedge clk) begin
		if (rst) begin
			cnt <= '0;
			running <= 1'b0;
			ta_ovf <= 1'b0;
			ta_flag <= 1'b0;
		end else begin
			ta_ovf <= wrap;
			if (ta_load) begin
				cnt <= ta_value;
				running <= 1'b1;
			end else if (wrap) begin
				cnt <= ta_value;
			end else if (running && round_tick) begin
				cnt <= cnt + 1'b1;
			end
			if (wrap)
				ta_flag <= 1'b1; // Set beats clear
			else if (ta_clear_flag)
				ta_flag <= 1'b0;
		end
	end

endmodule

`default_nettype wire
